// ==== flist.f ====
+incdir+include
verilog/pe_types_pkg.sv
verilog/pe_ctrl_pkg.sv
verilog/pe_ctrl_if.sv
verilog/pe_control.sv
verilog/filter_spad.sv
verilog/ifmap_spad.sv
verilog/psum_unit.sv
verilog/pe_top.sv
tests/pe_assert.sv
tests/pe_tb.sv

// ==== include/pe_defines.svh ====
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// activation and weight width
`define PE_ACT_BITS 8

// channel lanes packed into one ifmap word
`define PE_LANES 4

// partial sum width
`define PE_PSUM_BITS 24

// filter taps per row
`define PE_TAPS 3

// taps x max channels
`define PE_FILTER_DEPTH 12

// row length setting
`define PE_COL_BITS 6

`endif

// ==== tests/pe_assert.sv ====
`include "pe_defines.svh"

module pe_assert (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     filter_ready,
    input  logic                     ifmap_ready,
    input  logic                     ipsum_ready,
    input  logic                     opsum_enable,
    input  logic [`PE_PSUM_BITS-1:0] opsum,
    input  logic                     opsum_ready
);

    // read by the testbench
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // protocol checks

    idle_after_reset: assert property (@(posedge clk)
        rst |=> !(filter_ready || ifmap_ready || ipsum_ready || opsum_enable))
    else begin
        $error("ready or opsum_enable high in the cycle after reset");
        fail_count++;
    end

    // output held under back-pressure
    opsum_held: assert property (@(posedge clk) disable iff (rst)
        opsum_enable && !opsum_ready |=> opsum_enable && $stable(opsum))
    else begin
        $error("opsum_enable or opsum changed before opsum_ready");
        fail_count++;
    end

    ifmap_ipsum_apart: assert property (@(posedge clk) disable iff (rst)
        !(ifmap_ready && ipsum_ready))
    else begin
        $error("ifmap_ready and ipsum_ready high together");
        fail_count++;
    end

    filter_apart: assert property (@(posedge clk) disable iff (rst)
        !(filter_ready && (ipsum_ready || opsum_enable)))
    else begin
        $error("filter_ready high together with ipsum_ready or opsum_enable");
        fail_count++;
    end

endmodule

bind pe_top pe_assert i_assert (.*);

// ==== tests/pe_tb.sv ====
module pe_tb import pe_types_pkg::*, pe_ctrl_pkg::*; ();

    // three rows, (L + 2) x (compute + stalls + overhead) each
    localparam int TIMEOUT_CYCLES = (8 + 2 + 5 + 2 + 6 + 2) * (12 + 16 + 6) + 200;
    localparam int PSUM_HI = 2 ** ($bits(psum_t) - 1) - 1;
    localparam int PSUM_LO = -(2 ** ($bits(psum_t) - 1));

    logic        clk;
    logic        rst;
    logic        set_info;
    ch_size_t    ch_size;
    col_t        ifmap_column;
    logic        filter_enable;
    weight_t     filter;
    logic        filter_ready;
    logic        ifmap_enable;
    ifmap_word_t ifmap;
    logic        ifmap_ready;
    logic        ipsum_enable;
    psum_t       ipsum;
    logic        ipsum_ready;
    logic        opsum_enable;
    psum_t       opsum;
    logic        opsum_ready;

    logic [31:0] lfsr = 32'h253c_3e2a;
    int          cycles = 0;
    weight_t     w_row [12];
    ifmap_word_t words [64];
    psum_t       ipsums [64];
    psum_t       expected [64];

    pe_top i_dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_failed($sformatf("timeout, the run did not end within %0d cycles", cycles));
        end else if (i_dut.i_assert.fail_count != 0) begin
            stop_failed("a protocol assertion on the DUT failed");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random numbers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // one cycle in four
    function automatic bit stall_now();
        return rand_bits(2) == 2'b11;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic int clamp_psum(input int v);
        if (v > PSUM_HI) begin
            return PSUM_HI;
        end
        if (v < PSUM_LO) begin
            return PSUM_LO;
        end
        return v;
    endfunction

    // lane inside tap, saturating after every step
    function automatic psum_t window_result(input int k, input int ch);
        int acc;
        int a;
        int w;
        int ip;
        acc = 0;
        for (int t = 0; t < 3; t++) begin
            for (int l = 0; l < ch; l++) begin
                a   = $signed(words[k + t][l * $bits(act_t) +: $bits(act_t)]);
                w   = w_row[t * ch + l];
                acc = clamp_psum(acc + a * w);
            end
        end
        ip = ipsums[k];
        return psum_t'(clamp_psum(acc + ip));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_idle(input int n);
        repeat (n) begin
            assert (!(filter_ready || ifmap_ready || ipsum_ready || opsum_enable))
            else stop_failed("a ready or opsum_enable is high while the element is idle");
            next_cycle();
        end
    endtask

    // extreme rows drive every product to +/-128 x 128 and ipsum near a limit
    task automatic build_row(input int ch, input int len, input bit extreme);
        for (int i = 0; i < 3 * ch; i++) begin
            w_row[i] = extreme ? weight_t'(8'h80) : weight_t'(rand_bits(8));
        end
        for (int i = 0; i < len; i++) begin
            if (extreme) begin
                words[i] = (i < 3) ? 32'h8080_8080 : 32'h7f7f_7f7f;
            end else begin
                words[i] = rand_bits(32);
            end
        end
        for (int k = 0; k < len - 2; k++) begin
            ipsums[k] = psum_t'(rand_bits(24));
        end
        if (extreme) begin
            ipsums[0] = 24'h7f_ff00;
            ipsums[3] = 24'h80_0100;
        end
        for (int k = 0; k < len - 2; k++) begin
            expected[k] = window_result(k, ch);
        end
    endtask

    task automatic run_row(input int ch, input int len, input bit extreme);
        int fi;
        int wi;
        int pi;
        int oi;
        bit f_fire;
        bit i_fire;
        bit p_fire;
        build_row(ch, len, extreme);
        set_info     = 1'b1;
        ch_size      = ch_size_t'(ch);
        ifmap_column = col_t'(len);
        next_cycle();
        set_info = 1'b0;
        fi = 0;
        wi = 0;
        pi = 0;
        oi = 0;
        while (oi < len - 2) begin
            if (!filter_enable && fi < 3 * ch && !stall_now()) begin
                filter_enable = 1'b1;
                filter        = w_row[fi];
            end
            if (!ifmap_enable && wi < len && !stall_now()) begin
                ifmap_enable = 1'b1;
                ifmap        = words[wi];
            end
            if (!ipsum_enable && pi < len - 2 && !stall_now()) begin
                ipsum_enable = 1'b1;
                ipsum        = ipsums[pi];
            end
            opsum_ready = !stall_now();
            // everything sampled here holds until the next edge
            f_fire = filter_enable && filter_ready;
            i_fire = ifmap_enable && ifmap_ready;
            p_fire = ipsum_enable && ipsum_ready;
            if (opsum_enable && opsum_ready) begin
                assert (opsum === expected[oi])
                else stop_failed($sformatf("FAILED at time %0t: opsum expected %h, actual %h",
                                           $time, expected[oi], opsum));
                oi++;
            end
            next_cycle();
            if (f_fire) begin
                filter_enable = 1'b0;
                fi++;
            end
            if (i_fire) begin
                ifmap_enable = 1'b0;
                wi++;
            end
            if (p_fire) begin
                ipsum_enable = 1'b0;
                pi++;
            end
        end
        opsum_ready = 1'b0;
        expect_idle(5);
    endtask

    initial begin
        rst           = 1'b1;
        set_info      = 1'b0;
        ch_size       = '0;
        ifmap_column  = '0;
        filter_enable = 1'b0;
        filter        = '0;
        ifmap_enable  = 1'b0;
        ifmap         = '0;
        ipsum_enable  = 1'b0;
        ipsum         = '0;
        opsum_ready   = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        expect_idle(3);
        run_row(3, 8, 1'b0);
        run_row(4, 5, 1'b0);
        run_row(4, 6, 1'b1);
        if (i_dut.i_assert.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_failed("a protocol assertion on the DUT failed");
        end
    end

endmodule

// ==== verilog/filter_spad.sv ====
module filter_spad import pe_types_pkg::*, pe_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  weight_t filter,
    output weight_t weight,
    pe_ctrl_if.spad ctrl_bus
);

    weight_t     store [FILTER_DEPTH];
    filter_ptr_t wr_ptr;
    filter_ptr_t rd_ptr;
    filter_ptr_t ch_ext;
    filter_ptr_t two_ch;
    filter_ptr_t row_len;
    filter_ptr_t lane_off;
    tap_idx_t    tap;

    assign ch_ext  = filter_ptr_t'(ctrl_bus.cfg_ch_size);
    assign two_ch  = ch_ext << 1;
    assign row_len = ch_ext + two_ch;

    assign ctrl_bus.filter_full = (wr_ptr == row_len);
    assign ctrl_bus.mac_last    = (ctrl_bus.phase == COMPUTE) && (rd_ptr == row_len - 1'b1);

    // write side, cleared while idle so each row loads afresh
    always_ff @(posedge clk) begin
        if (rst || ctrl_bus.phase == IDLE) begin
            wr_ptr <= '0;
        end else if (ctrl_bus.filter_take) begin
            wr_ptr <= wr_ptr + filter_ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_bus.filter_take) begin
            store[wr_ptr] <= filter;
        end
    end

    // one byte per compute cycle
    always_ff @(posedge clk) begin
        if (rst || ctrl_bus.phase != COMPUTE || ctrl_bus.mac_last) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr + filter_ptr_t'(1);
        end
    end

    assign weight = store[rd_ptr];

    // byte = tap * ch + lane
    always_comb begin
        if (rd_ptr >= two_ch) begin
            tap      = tap_idx_t'(2);
            lane_off = rd_ptr - two_ch;
        end else if (rd_ptr >= ch_ext) begin
            tap      = tap_idx_t'(1);
            lane_off = rd_ptr - ch_ext;
        end else begin
            tap      = tap_idx_t'(0);
            lane_off = rd_ptr;
        end
    end

    assign ctrl_bus.mac_tap  = tap;
    assign ctrl_bus.mac_lane = lane_off[$bits(lane_idx_t)-1:0];

endmodule

// ==== verilog/ifmap_spad.sv ====
module ifmap_spad import pe_types_pkg::*, pe_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ifmap_word_t ifmap,
    output act_t        act,
    pe_ctrl_if.spad     ctrl_bus
);

    // word 0 is the oldest
    ifmap_word_t window [TAP_COUNT];
    tap_idx_t    fill_cnt;
    ifmap_word_t tap_word;

    assign ctrl_bus.window_full = (fill_cnt == tap_idx_t'(TAP_COUNT));

    always_ff @(posedge clk) begin
        if (rst || ctrl_bus.phase == IDLE) begin
            fill_cnt <= '0;
        end else if (ctrl_bus.ifmap_take && !ctrl_bus.window_full) begin
            fill_cnt <= fill_cnt + tap_idx_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fill in order during load, slide by one word on shift

    always_ff @(posedge clk) begin
        if (ctrl_bus.ifmap_take) begin
            if (ctrl_bus.phase == SHIFT) begin
                for (int i = 0; i < TAP_COUNT - 1; i++) begin
                    window[i] <= window[i + 1];
                end
                window[TAP_COUNT - 1] <= ifmap;
            end else begin
                window[fill_cnt] <= ifmap;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word by tap, then four-to-one lane mux

    always_comb begin
        case (ctrl_bus.mac_tap)
            tap_idx_t'(0): tap_word = window[0];
            tap_idx_t'(1): tap_word = window[1];
            default:       tap_word = window[TAP_COUNT - 1];
        endcase
    end

    always_comb begin
        case (ctrl_bus.mac_lane)
            lane_idx_t'(0): act = tap_word[0*$bits(act_t) +: $bits(act_t)];
            lane_idx_t'(1): act = tap_word[1*$bits(act_t) +: $bits(act_t)];
            lane_idx_t'(2): act = tap_word[2*$bits(act_t) +: $bits(act_t)];
            default:        act = tap_word[3*$bits(act_t) +: $bits(act_t)];
        endcase
    end

endmodule

// ==== verilog/pe_control.sv ====
module pe_control import pe_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     set_info,
    input  ch_size_t ch_size,
    input  col_t     ifmap_column,
    input  logic     filter_enable,
    input  logic     ifmap_enable,
    input  logic     ipsum_enable,
    input  logic     opsum_ready,
    output logic     filter_ready,
    output logic     ifmap_ready,
    output logic     ipsum_ready,
    output logic     opsum_enable,
    output logic     mac_en,
    output logic     mac_first,
    output logic     ipsum_add,
    pe_ctrl_if.ctrl  ctrl_bus
);

    pe_phase_e state;
    pe_phase_e next_state;
    ch_size_t  cfg_ch_size;
    col_t      cfg_col;
    col_t      out_cnt;
    logic      opsum_take;
    logic      row_done;

    ////////////////////////////////////////////////////////////////////////////
    // layer setting

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_ch_size <= '0;
            cfg_col     <= '0;
        end else if (state == IDLE && set_info) begin
            cfg_ch_size <= ch_size;
            cfg_col     <= ifmap_column;
        end
    end

    assign ctrl_bus.cfg_ch_size = cfg_ch_size;
    assign ctrl_bus.phase       = state;

    ////////////////////////////////////////////////////////////////////////////
    // handshakes and strobes

    assign filter_ready = (state == LOAD) && !ctrl_bus.filter_full;
    assign ifmap_ready  = ((state == LOAD) && !ctrl_bus.window_full) || (state == SHIFT);
    assign ipsum_ready  = (state == ACCUM);
    assign opsum_enable = (state == OUTPUT);

    assign ctrl_bus.filter_take = filter_ready && filter_enable;
    assign ctrl_bus.ifmap_take  = ifmap_ready && ifmap_enable;
    assign ipsum_add            = ipsum_ready && ipsum_enable;
    assign opsum_take           = opsum_enable && opsum_ready;

    // read pointer sits at zero on the first compute cycle only
    assign mac_en    = (state == COMPUTE);
    assign mac_first = mac_en && (ctrl_bus.mac_tap == '0) && (ctrl_bus.mac_lane == '0);

    ////////////////////////////////////////////////////////////////////////////
    // output counting, L - 2 per row

    assign row_done = (out_cnt == cfg_col - col_t'(3));

    always_ff @(posedge clk) begin
        if (rst || state == IDLE) begin
            out_cnt <= '0;
        end else if (opsum_take) begin
            out_cnt <= out_cnt + col_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (set_info) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                if (ctrl_bus.filter_full && ctrl_bus.window_full) begin
                    next_state = COMPUTE;
                end
            end
            COMPUTE: begin
                if (ctrl_bus.mac_last) begin
                    next_state = ACCUM;
                end
            end
            ACCUM: begin
                if (ipsum_add) begin
                    next_state = OUTPUT;
                end
            end
            OUTPUT: begin
                if (opsum_take) begin
                    next_state = row_done ? IDLE : SHIFT;
                end
            end
            SHIFT: begin
                if (ctrl_bus.ifmap_take) begin
                    next_state = COMPUTE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

// ==== verilog/pe_ctrl_if.sv ====
interface pe_ctrl_if;

    // from the controller
    pe_ctrl_pkg::pe_phase_e phase;
    pe_ctrl_pkg::ch_size_t  cfg_ch_size;
    logic                   filter_take;
    logic                   ifmap_take;

    // from the scratchpads
    logic                   filter_full;
    pe_ctrl_pkg::tap_idx_t  mac_tap;
    pe_ctrl_pkg::lane_idx_t mac_lane;
    logic                   mac_last;
    logic                   window_full;

    modport ctrl (
        output phase, cfg_ch_size, filter_take, ifmap_take,
        input  filter_full, mac_tap, mac_lane, mac_last, window_full
    );

    modport spad (
        input  phase, cfg_ch_size, filter_take, ifmap_take,
        output filter_full, mac_tap, mac_lane, mac_last, window_full
    );

endinterface

// ==== verilog/pe_ctrl_pkg.sv ====
`include "pe_defines.svh"

package pe_ctrl_pkg;

    localparam int TAP_COUNT    = `PE_TAPS;
    localparam int FILTER_DEPTH = `PE_FILTER_DEPTH;

    // one window position per pass through COMPUTE..OUTPUT
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        ACCUM,
        OUTPUT,
        SHIFT
    } pe_phase_e;

    typedef logic [$clog2(`PE_LANES):0]          ch_size_t;
    typedef logic [`PE_COL_BITS-1:0]             col_t;
    typedef logic [$clog2(`PE_TAPS)-1:0]         tap_idx_t;
    typedef logic [$clog2(`PE_LANES)-1:0]        lane_idx_t;
    typedef logic [$clog2(`PE_FILTER_DEPTH)-1:0] filter_ptr_t;

endpackage

// ==== verilog/pe_top.sv ====
module pe_top import pe_types_pkg::*, pe_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        set_info,
    input  ch_size_t    ch_size,
    input  col_t        ifmap_column,
    input  logic        filter_enable,
    input  weight_t     filter,
    output logic        filter_ready,
    input  logic        ifmap_enable,
    input  ifmap_word_t ifmap,
    output logic        ifmap_ready,
    input  logic        ipsum_enable,
    input  psum_t       ipsum,
    output logic        ipsum_ready,
    output logic        opsum_enable,
    output psum_t       opsum,
    input  logic        opsum_ready
);

    weight_t weight;
    act_t    act;
    logic    mac_en;
    logic    mac_first;
    logic    ipsum_add;

    pe_ctrl_if ctrl_bus ();

    pe_control i_control (
        .clk           (clk),
        .rst           (rst),
        .set_info      (set_info),
        .ch_size       (ch_size),
        .ifmap_column  (ifmap_column),
        .filter_enable (filter_enable),
        .ifmap_enable  (ifmap_enable),
        .ipsum_enable  (ipsum_enable),
        .opsum_ready   (opsum_ready),
        .filter_ready  (filter_ready),
        .ifmap_ready   (ifmap_ready),
        .ipsum_ready   (ipsum_ready),
        .opsum_enable  (opsum_enable),
        .mac_en        (mac_en),
        .mac_first     (mac_first),
        .ipsum_add     (ipsum_add),
        .ctrl_bus      (ctrl_bus.ctrl)
    );

    filter_spad i_filter_spad (
        .clk      (clk),
        .rst      (rst),
        .filter   (filter),
        .weight   (weight),
        .ctrl_bus (ctrl_bus.spad)
    );

    ifmap_spad i_ifmap_spad (
        .clk      (clk),
        .rst      (rst),
        .ifmap    (ifmap),
        .act      (act),
        .ctrl_bus (ctrl_bus.spad)
    );

    psum_unit i_psum_unit (
        .clk       (clk),
        .rst       (rst),
        .act       (act),
        .weight    (weight),
        .ipsum     (ipsum),
        .mac_en    (mac_en),
        .mac_first (mac_first),
        .ipsum_add (ipsum_add),
        .psum      (opsum)
    );

endmodule

// ==== verilog/pe_types_pkg.sv ====
`include "pe_defines.svh"

package pe_types_pkg;

    // one signed channel value
    typedef logic signed [`PE_ACT_BITS-1:0] act_t;

    typedef logic signed [`PE_ACT_BITS-1:0] weight_t;

    // lane 0 sits in the low byte
    typedef logic [`PE_LANES*`PE_ACT_BITS-1:0] ifmap_word_t;

    // full precision product of act_t and weight_t
    typedef logic signed [2*`PE_ACT_BITS-1:0] product_t;

    typedef logic signed [`PE_PSUM_BITS-1:0] psum_t;

endpackage

// ==== verilog/psum_unit.sv ====
module psum_unit import pe_types_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  act_t    act,
    input  weight_t weight,
    input  psum_t   ipsum,
    input  logic    mac_en,
    input  logic    mac_first,
    input  logic    ipsum_add,
    output psum_t   psum
);

    localparam psum_t PSUM_MAX = {1'b0, {($bits(psum_t)-1){1'b1}}};
    localparam psum_t PSUM_MIN = ~PSUM_MAX;

    product_t                      product;
    psum_t                         base;
    psum_t                         addend;
    logic signed [$bits(psum_t):0] sum_wide;
    psum_t                         sum_sat;

    ////////////////////////////////////////////////////////////////////////////
    // multiply and add

    assign product = act * weight;

    // start over from zero on the first tap
    assign base   = mac_first ? '0 : psum;
    assign addend = mac_en ? psum_t'(product) : ipsum;

    assign sum_wide = base + addend;

    // top two bits disagree on signed overflow
    always_comb begin
        if (sum_wide[$bits(psum_t)] != sum_wide[$bits(psum_t)-1]) begin
            sum_sat = sum_wide[$bits(psum_t)] ? PSUM_MIN : PSUM_MAX;
        end else begin
            sum_sat = sum_wide[$bits(psum_t)-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // partial sum register

    always_ff @(posedge clk) begin
        if (rst) begin
            psum <= '0;
        end else if (mac_en || ipsum_add) begin
            psum <= sum_sat;
        end
    end

endmodule
